//--- renameGolden.txt
// kind valid src1_0 src2_0 dst_0 src1_1 src2_1 dst_1 | psrc1 psrc2 pdst oldPdst per slot
// kind 01 is a group, 02 a release with the register in column 2 and a starve flag in column 3
01 03 01 02 03 04 05 06 01 02 20 03 04 05 21 06
01 03 03 07 08 08 03 08 20 07 22 08 22 20 23 22
01 03 08 06 09 09 03 0a 23 21 24 09 24 20 25 0a
// Register zero and invalid slots.
01 03 00 05 00 00 0a 0b 00 05 00 00 00 25 26 0b
01 01 0b 03 0c 0c 09 0d 26 20 27 0c 27 24 00 00
01 02 02 02 0e 0e 01 0f 02 02 00 00 0e 01 28 0f
// Drain the rest of the free list.
01 03 01 03 10 10 06 11 01 20 29 10 29 21 2a 11
01 03 08 09 12 0a 0b 13 23 24 2b 12 25 26 2c 13
01 03 0c 0f 14 10 11 15 27 28 2d 14 29 2a 2e 15
01 03 12 13 16 14 15 17 2b 2c 2f 16 2d 2e 30 17
01 03 16 17 18 18 18 18 2f 30 31 18 31 31 32 31
01 03 18 00 19 19 0d 1a 32 00 33 19 33 0d 34 1a
01 03 1a 19 1b 02 04 1c 34 33 35 1b 02 04 36 1c
01 03 1b 1c 1d 05 07 1e 35 36 37 1d 05 07 38 1e
01 03 1d 1e 1f 1f 01 01 37 38 39 1f 39 01 3a 01
01 03 01 1f 02 02 02 03 3a 39 3b 02 3b 3b 3c 20
01 03 03 00 04 04 03 05 3c 00 3d 04 3d 3c 3e 05
01 01 05 04 06 00 00 00 3e 3d 3f 21 00 00 00 00
// This group waits for two releases.
01 03 06 01 07 07 08 08 3f 3a 03 07 03 23 06 23
02 03 01 00 00 00 00 00 00 00 00 00 00 00 00 00
02 06 00 00 00 00 00 00 00 00 00 00 00 00 00 00
02 08 00 00 00 00 00 00 00 00 00 00 00 00 00 00
02 09 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 03 07 08 09 09 00 0a 03 06 08 24 08 00 09 25

//--- sources.f
renamePkg.sv
renameIntake.sv
renameMap.sv
renameLane.sv
renameEmit.sv
renameStage.sv
tbClock.sv
renameTb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module renameTb -f sources.f -o renameSim

./obj_dir/renameSim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed, see sim.log."
    exit 1
fi

//--- renameTb.sv
`default_nettype none

module renameTb
    import renamePkg::*;
();

    localparam int width      = 2;
    localparam int recWords   = 16;    // One golden record per line.
    localparam int maxRecords = 64;
    localparam int memWords   = recWords * maxRecords;
    localparam logic [7:0] kindGroup = 8'h01;

    logic                        clk;
    logic                        rstN;
    logic                        inReq;
    logic                        inAck;
    logic [width-1:0]            inValid;
    logic [width*AREG_BITS-1:0]  inSrc1;
    logic [width*AREG_BITS-1:0]  inSrc2;
    logic [width*AREG_BITS-1:0]  inDst;
    logic                        outReq;
    logic                        outAck;
    logic [width-1:0]            outValid;
    logic [width*PREG_BITS-1:0]  outPsrc1;
    logic [width*PREG_BITS-1:0]  outPsrc2;
    logic [width*PREG_BITS-1:0]  outPdst;
    logic [width*PREG_BITS-1:0]  outOldPdst;
    logic                        relValid;
    pregAddrT                    relPreg;

    logic [7:0]  golden [0:memWords-1];
    int          groupBase [$];
    int          numRecords;
    int          sentCount;
    int          recvCount;
    int          cycleCount = 0;
    int          cycleLimit = 200;

    tbClock u_clock (.clk);

    renameStage #(.machineWidth(width), .numPregs(64)) u_dut (
        .clk, .rstN, .inReq, .inAck, .inValid, .inSrc1, .inSrc2, .inDst,
        .outReq, .outAck, .outValid, .outPsrc1, .outPsrc2, .outPdst, .outOldPdst,
        .relValid, .relPreg
    );

    // ====================
    // Error handling
    // ====================

    task automatic failRun();
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic checkValue(string name, int expected, int actual);
        assert (expected == actual) else begin
            $display("ERR time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
            failRun();
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the golden records did not finish within %0d cycles.", cycleLimit);
            failRun();
        end
    end

    // ====================
    // Decode side and releases
    // ====================

    task automatic sendGroup(int base);
        logic [width*AREG_BITS-1:0] src1;
        logic [width*AREG_BITS-1:0] src2;
        logic [width*AREG_BITS-1:0] dst;
        for (int s = 0; s < width; s++) begin
            src1[s*AREG_BITS +: AREG_BITS] = golden[base + 2 + 3*s][AREG_BITS-1:0];
            src2[s*AREG_BITS +: AREG_BITS] = golden[base + 3 + 3*s][AREG_BITS-1:0];
            dst[s*AREG_BITS +: AREG_BITS]  = golden[base + 4 + 3*s][AREG_BITS-1:0];
        end
        @(posedge clk);
        inValid <= golden[base + 1][width-1:0];
        inSrc1  <= src1;
        inSrc2  <= src2;
        inDst   <= dst;
        inReq   <= 1'b1;
        do begin
            @(posedge clk);
        end while (!inAck);
        inReq <= 1'b0;
        do begin
            @(posedge clk);
        end while (inAck);    // Data stays put until ack has fallen.
        sentCount++;
    endtask

    // The last group sent must sit in intake while the free list is empty.
    task automatic checkStarved();
        while (recvCount < sentCount - 1) begin
            @(posedge clk);
        end
        repeat (20) begin
            @(posedge clk);
            assert (!outReq && (recvCount == sentCount - 1)) else begin
                $display("A group was emitted at time %0t with an empty free list.", $time);
                failRun();
            end
        end
    endtask

    task automatic releasePreg(int base);
        if (golden[base + 2][0]) begin
            checkStarved();
        end
        @(posedge clk);
        relValid <= 1'b1;
        relPreg  <= golden[base + 1][PREG_BITS-1:0];
        @(posedge clk);
        relValid <= 1'b0;
    endtask

    task automatic driveRecords();
        int base;
        for (int r = 0; r < numRecords; r++) begin
            base = r * recWords;
            if (golden[base] == kindGroup) begin
                sendGroup(base);
            end else begin
                releasePreg(base);
            end
        end
    endtask

    // ====================
    // Issue side
    // ====================

    task automatic checkGroup(int base);
        checkValue("outValid", int'(golden[base + 1]), int'(outValid));
        for (int s = 0; s < width; s++) begin
            checkValue($sformatf("outPsrc1[%0d]", s), int'(golden[base + 8 + 4*s]),
                       int'(outPsrc1[s*PREG_BITS +: PREG_BITS]));
            checkValue($sformatf("outPsrc2[%0d]", s), int'(golden[base + 9 + 4*s]),
                       int'(outPsrc2[s*PREG_BITS +: PREG_BITS]));
            checkValue($sformatf("outPdst[%0d]", s), int'(golden[base + 10 + 4*s]),
                       int'(outPdst[s*PREG_BITS +: PREG_BITS]));
            checkValue($sformatf("outOldPdst[%0d]", s), int'(golden[base + 11 + 4*s]),
                       int'(outOldPdst[s*PREG_BITS +: PREG_BITS]));
        end
    endtask

    task automatic collectGroups();
        int delay;
        for (int g = 0; g < groupBase.size(); g++) begin
            do begin
                @(posedge clk);
            end while (!outReq);
            delay = int'($urandom % 6);    // Random ack latency for back-pressure.
            repeat (delay) @(posedge clk);
            checkGroup(groupBase[g]);
            outAck <= 1'b1;
            do begin
                @(posedge clk);
            end while (outReq);
            delay = int'($urandom % 6);
            repeat (delay) @(posedge clk);
            outAck <= 1'b0;
            recvCount++;
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        rstN     <= 1'b0;
        inReq    <= 1'b0;
        inValid  <= '0;
        inSrc1   <= '0;
        inSrc2   <= '0;
        inDst    <= '0;
        outAck   <= 1'b0;
        relValid <= 1'b0;
        relPreg  <= '0;
        sentCount = 0;
        recvCount = 0;
        void'($urandom(51957));

        for (int w = 0; w < memWords; w++) begin
            golden[w] = 8'h00;
        end
        $readmemh("renameGolden.txt", golden);
        numRecords = 0;
        while ((numRecords < maxRecords) && (golden[numRecords * recWords] != 8'h00)) begin
            if (golden[numRecords * recWords] == kindGroup) begin
                groupBase.push_back(numRecords * recWords);
            end
            numRecords++;
        end
        cycleLimit = 40 * numRecords + 200;
        assert (numRecords > 0) else begin
            $display("The golden file holds no records.");
            failRun();
        end

        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);

        fork
            driveRecords();
            collectGroups();
        join

        // Nothing may follow the last group.
        repeat (20) begin
            @(posedge clk);
            assert (!outReq) else begin
                $display("An extra group appeared at time %0t after the last one.", $time);
                failRun();
            end
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tbClock.sv
`default_nettype none

module tbClock #(
    parameter int halfPeriod = 5
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #halfPeriod clk = ~clk;    // Full period is 10 time units.

endmodule

`default_nettype wire

//--- renameStage.sv
`default_nettype none

module renameStage
    import renamePkg::*;
#(
    parameter int machineWidth = 2,
    parameter int numPregs     = 64
) (
    input  wire logic                              clk,
    input  wire logic                              rstN,
    input  wire logic                              inReq,
    output logic                                   inAck,
    input  wire logic [machineWidth-1:0]           inValid,
    input  wire logic [machineWidth*AREG_BITS-1:0] inSrc1,
    input  wire logic [machineWidth*AREG_BITS-1:0] inSrc2,
    input  wire logic [machineWidth*AREG_BITS-1:0] inDst,
    output logic                                   outReq,
    input  wire logic                              outAck,
    output logic [machineWidth-1:0]                outValid,
    output logic [machineWidth*PREG_BITS-1:0]      outPsrc1,
    output logic [machineWidth*PREG_BITS-1:0]      outPsrc2,
    output logic [machineWidth*PREG_BITS-1:0]      outPdst,
    output logic [machineWidth*PREG_BITS-1:0]      outOldPdst,
    input  wire logic                              relValid,
    input  wire pregAddrT                          relPreg
);

    logic                              take;
    logic                              grpFull;
    logic                              allocOk;
    logic [machineWidth-1:0]           grpValid;
    logic [machineWidth*AREG_BITS-1:0] grpSrc1;
    logic [machineWidth*AREG_BITS-1:0] grpSrc2;
    logic [machineWidth*AREG_BITS-1:0] grpDst;
    logic [machineWidth*PREG_BITS-1:0] mapSrc1;
    logic [machineWidth*PREG_BITS-1:0] mapSrc2;
    logic [machineWidth*PREG_BITS-1:0] mapOldDst;
    logic [machineWidth*PREG_BITS-1:0] allocPdst;
    logic [machineWidth*PREG_BITS-1:0] laneSrc1;
    logic [machineWidth*PREG_BITS-1:0] laneSrc2;
    logic [machineWidth*PREG_BITS-1:0] lanePdst;
    logic [machineWidth*PREG_BITS-1:0] laneOldPdst;

    renameIntake #(.machineWidth(machineWidth)) u_intake (
        .clk, .rstN, .inReq, .inAck, .inValid, .inSrc1, .inSrc2, .inDst,
        .take, .grpFull, .grpValid, .grpSrc1, .grpSrc2, .grpDst
    );

    renameMap #(.machineWidth(machineWidth), .numPregs(numPregs)) u_map (
        .clk, .rstN, .grpValid, .grpSrc1, .grpSrc2, .grpDst, .take, .relValid, .relPreg,
        .mapSrc1, .mapSrc2, .mapOldDst, .allocPdst, .allocOk
    );

    // Each lane sees the whole group but only compares against lower slots.
    for (genvar l = 0; l < machineWidth; l++) begin : genLane
        renameLane #(.machineWidth(machineWidth), .lane(l)) u_lane (
            .src1       (grpSrc1[l*AREG_BITS +: AREG_BITS]),
            .src2       (grpSrc2[l*AREG_BITS +: AREG_BITS]),
            .dst        (grpDst[l*AREG_BITS +: AREG_BITS]),
            .valid      (grpValid[l]),
            .mapSrc1    (mapSrc1[l*PREG_BITS +: PREG_BITS]),
            .mapSrc2    (mapSrc2[l*PREG_BITS +: PREG_BITS]),
            .mapOldDst  (mapOldDst[l*PREG_BITS +: PREG_BITS]),
            .myPdst     (allocPdst[l*PREG_BITS +: PREG_BITS]),
            .olderValid (grpValid),
            .olderDst   (grpDst),
            .olderPdst  (allocPdst),
            .psrc1      (laneSrc1[l*PREG_BITS +: PREG_BITS]),
            .psrc2      (laneSrc2[l*PREG_BITS +: PREG_BITS]),
            .pdst       (lanePdst[l*PREG_BITS +: PREG_BITS]),
            .oldPdst    (laneOldPdst[l*PREG_BITS +: PREG_BITS])
        );
    end

    renameEmit #(.machineWidth(machineWidth)) u_emit (
        .clk, .rstN, .grpFull, .allocOk, .take,
        .laneValid (grpValid),
        .laneSrc1, .laneSrc2, .lanePdst, .laneOldPdst,
        .outReq, .outAck, .outValid, .outPsrc1, .outPsrc2, .outPdst, .outOldPdst
    );

endmodule

`default_nettype wire

//--- renameEmit.sv
`default_nettype none

module renameEmit
    import renamePkg::*;
#(
    parameter int machineWidth = 2
) (
    input  wire logic                              clk,
    input  wire logic                              rstN,
    input  wire logic                              grpFull,
    input  wire logic                              allocOk,
    output logic                                   take,
    input  wire logic [machineWidth-1:0]           laneValid,
    input  wire logic [machineWidth*PREG_BITS-1:0] laneSrc1,
    input  wire logic [machineWidth*PREG_BITS-1:0] laneSrc2,
    input  wire logic [machineWidth*PREG_BITS-1:0] lanePdst,
    input  wire logic [machineWidth*PREG_BITS-1:0] laneOldPdst,
    output logic                                   outReq,
    input  wire logic                              outAck,
    output logic [machineWidth-1:0]                outValid,
    output logic [machineWidth*PREG_BITS-1:0]      outPsrc1,
    output logic [machineWidth*PREG_BITS-1:0]      outPsrc2,
    output logic [machineWidth*PREG_BITS-1:0]      outPdst,
    output logic [machineWidth*PREG_BITS-1:0]      outOldPdst
);

    emitStateT state;

    // The output register must be free, otherwise the group stays in intake.
    assign take   = grpFull && allocOk && (state == EMIT_EMPTY);
    assign outReq = (state == EMIT_REQ);

    // ====================
    // Output handshake FSM
    // ====================

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= EMIT_EMPTY;
        end else begin
            case (state)
                EMIT_EMPTY: begin
                    if (take) begin
                        state <= EMIT_REQ;
                    end
                end
                EMIT_REQ: begin
                    if (outAck) begin
                        state <= EMIT_WAIT;    // Req drops and the data stays until ack falls.
                    end
                end
                EMIT_WAIT: begin
                    if (!outAck) begin
                        state <= EMIT_EMPTY;
                    end
                end
                default: begin
                    state <= EMIT_EMPTY;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            outValid   <= laneValid;
            outPsrc1   <= laneSrc1;
            outPsrc2   <= laneSrc2;
            outPdst    <= lanePdst;
            outOldPdst <= laneOldPdst;
        end
    end

endmodule

`default_nettype wire

//--- renameLane.sv
`default_nettype none

module renameLane
    import renamePkg::*;
#(
    parameter int machineWidth = 2,
    parameter int lane         = 0
) (
    input  wire aregAddrT                          src1,
    input  wire aregAddrT                          src2,
    input  wire aregAddrT                          dst,
    input  wire logic                              valid,
    input  wire pregAddrT                          mapSrc1,
    input  wire pregAddrT                          mapSrc2,
    input  wire pregAddrT                          mapOldDst,
    input  wire pregAddrT                          myPdst,
    input  wire logic [machineWidth-1:0]           olderValid,
    input  wire logic [machineWidth*AREG_BITS-1:0] olderDst,
    input  wire logic [machineWidth*PREG_BITS-1:0] olderPdst,
    output pregAddrT                               psrc1,
    output pregAddrT                               psrc2,
    output pregAddrT                               pdst,
    output pregAddrT                               oldPdst
);

    logic writes;

    // Walks the older slots in order, so the youngest matching writer is kept.
    function automatic pregAddrT resolve(
        aregAddrT                          areg,
        pregAddrT                          tableVal,
        logic [machineWidth-1:0]           oValid,
        logic [machineWidth*AREG_BITS-1:0] oDst,
        logic [machineWidth*PREG_BITS-1:0] oPdst
    );
        pregAddrT result;
        result = tableVal;
        for (int j = 0; j < lane; j++) begin
            if (oValid[j] && (areg != '0) && (oDst[j*AREG_BITS +: AREG_BITS] == areg)) begin
                result = oPdst[j*PREG_BITS +: PREG_BITS];
            end
        end
        return result;
    endfunction

    assign writes = valid && (dst != '0);

    assign psrc1   = resolve(src1, mapSrc1, olderValid, olderDst, olderPdst);
    assign psrc2   = resolve(src2, mapSrc2, olderValid, olderDst, olderPdst);
    assign pdst    = writes ? myPdst : '0;
    // The previous mapping may itself come from an older slot of this group.
    assign oldPdst = writes ? resolve(dst, mapOldDst, olderValid, olderDst, olderPdst) : '0;

endmodule

`default_nettype wire

//--- renameMap.sv
`default_nettype none

module renameMap
    import renamePkg::*;
#(
    parameter int machineWidth = 2,
    parameter int numPregs     = 64
) (
    input  wire logic                              clk,
    input  wire logic                              rstN,
    input  wire logic [machineWidth-1:0]           grpValid,
    input  wire logic [machineWidth*AREG_BITS-1:0] grpSrc1,
    input  wire logic [machineWidth*AREG_BITS-1:0] grpSrc2,
    input  wire logic [machineWidth*AREG_BITS-1:0] grpDst,
    input  wire logic                              take,
    input  wire logic                              relValid,
    input  wire pregAddrT                          relPreg,
    output logic [machineWidth*PREG_BITS-1:0]      mapSrc1,
    output logic [machineWidth*PREG_BITS-1:0]      mapSrc2,
    output logic [machineWidth*PREG_BITS-1:0]      mapOldDst,
    output logic [machineWidth*PREG_BITS-1:0]      allocPdst,
    output logic                                   allocOk
);

    localparam int freeDepth = numPregs - NUM_AREGS;
    localparam int PTR_BITS  = $clog2(freeDepth);
    localparam int CNT_BITS  = $clog2(freeDepth + 1);

    typedef logic [PTR_BITS-1:0] ptrT;
    typedef logic [CNT_BITS-1:0] cntT;

    pregAddrT aliasTable [NUM_AREGS];
    pregAddrT freeList [freeDepth];
    ptrT      head;
    ptrT      tail;
    cntT      count;
    cntT      needCount;
    cntT      takeCount;

    aregAddrT                slotSrc1 [machineWidth];
    aregAddrT                slotSrc2 [machineWidth];
    aregAddrT                slotDst [machineWidth];
    logic [machineWidth-1:0] need;

    // Circular pointer step. The step never exceeds the FIFO depth.
    function automatic ptrT wrapAdd(ptrT base, int step);
        int sum;
        sum = int'(base) + step;
        if (sum >= freeDepth) begin
            sum = sum - freeDepth;
        end
        return ptrT'(sum);
    endfunction

    for (genvar i = 0; i < machineWidth; i++) begin : genSlot
        assign slotSrc1[i] = grpSrc1[i*AREG_BITS +: AREG_BITS];
        assign slotSrc2[i] = grpSrc2[i*AREG_BITS +: AREG_BITS];
        assign slotDst[i]  = grpDst[i*AREG_BITS +: AREG_BITS];
        assign need[i]     = grpValid[i] && (slotDst[i] != '0);
    end

    // ====================
    // Lookup and allocation
    // ====================

    always_comb begin
        int offset;
        offset = 0;
        for (int i = 0; i < machineWidth; i++) begin
            mapSrc1[i*PREG_BITS +: PREG_BITS]   = aliasTable[slotSrc1[i]];
            mapSrc2[i*PREG_BITS +: PREG_BITS]   = aliasTable[slotSrc2[i]];
            mapOldDst[i*PREG_BITS +: PREG_BITS] = aliasTable[slotDst[i]];
            allocPdst[i*PREG_BITS +: PREG_BITS] = freeList[wrapAdd(head, offset)];
            if (need[i]) begin
                offset = offset + 1;    // Only needing slots consume an entry.
            end
        end
        needCount = cntT'(offset);
    end

    assign allocOk   = (count >= needCount);
    assign takeCount = take ? needCount : '0;
    assign tail      = wrapAdd(head, int'(count));

    // ====================
    // Table and free-list update
    // ====================

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int a = 0; a < NUM_AREGS; a++) begin
                aliasTable[a] <= pregAddrT'(a);
            end
            for (int f = 0; f < freeDepth; f++) begin
                freeList[f] <= pregAddrT'(NUM_AREGS + f);
            end
            head  <= '0;
            count <= cntT'(freeDepth);
        end else begin
            if (take) begin
                // Later slots overwrite earlier ones, so the youngest writer wins.
                for (int i = 0; i < machineWidth; i++) begin
                    if (need[i]) begin
                        aliasTable[slotDst[i]] <= allocPdst[i*PREG_BITS +: PREG_BITS];
                    end
                end
                head <= wrapAdd(head, int'(needCount));
            end
            if (relValid) begin
                freeList[tail] <= relPreg;
            end
            count <= count - takeCount + cntT'(relValid);
        end
    end

endmodule

`default_nettype wire

//--- renameIntake.sv
`default_nettype none

module renameIntake
    import renamePkg::*;
#(
    parameter int machineWidth = 2
) (
    input  wire logic                              clk,
    input  wire logic                              rstN,
    input  wire logic                              inReq,
    output logic                                   inAck,
    input  wire logic [machineWidth-1:0]           inValid,
    input  wire logic [machineWidth*AREG_BITS-1:0] inSrc1,
    input  wire logic [machineWidth*AREG_BITS-1:0] inSrc2,
    input  wire logic [machineWidth*AREG_BITS-1:0] inDst,
    input  wire logic                              take,
    output logic                                   grpFull,
    output logic [machineWidth-1:0]                grpValid,
    output logic [machineWidth*AREG_BITS-1:0]      grpSrc1,
    output logic [machineWidth*AREG_BITS-1:0]      grpSrc2,
    output logic [machineWidth*AREG_BITS-1:0]      grpDst
);

    intakeStateT state;
    logic        accept;

    // A request is only accepted once the previous group has been taken.
    assign accept = (state == INTAKE_IDLE) && inReq && !grpFull;
    assign inAck  = (state == INTAKE_ACK);

    // ====================
    // Handshake FSM
    // ====================

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= INTAKE_IDLE;
            grpFull <= 1'b0;
        end else begin
            case (state)
                INTAKE_IDLE: begin
                    if (accept) begin
                        state <= INTAKE_ACK;
                    end
                end
                INTAKE_ACK: begin
                    if (!inReq) begin
                        state <= INTAKE_IDLE;    // Ack drops one cycle after req is seen low.
                    end
                end
                default: begin
                    state <= INTAKE_IDLE;
                end
            endcase

            if (accept) begin
                grpFull <= 1'b1;
            end else if (take) begin
                grpFull <= 1'b0;
            end
        end
    end

    // Holding register for the decoded group.
    always_ff @(posedge clk) begin
        if (accept) begin
            grpValid <= inValid;
            grpSrc1  <= inSrc1;
            grpSrc2  <= inSrc2;
            grpDst   <= inDst;
        end
    end

endmodule

`default_nettype wire

//--- renamePkg.sv
`default_nettype none

package renamePkg;

    // ====================
    // Register address widths
    // ====================

    localparam int AREG_BITS = 5;
    localparam int PREG_BITS = 6;
    localparam int NUM_AREGS = 32;    // Registers 0 to NUM_AREGS-1 start out mapped one to one.

    typedef logic [AREG_BITS-1:0] aregAddrT;
    typedef logic [PREG_BITS-1:0] pregAddrT;

    // ====================
    // Handshake state machines
    // ====================

    typedef enum logic {
        INTAKE_IDLE,    // Ready for a new request once the held group is gone.
        INTAKE_ACK      // Ack is up, waiting for req to drop.
    } intakeStateT;

    typedef enum logic [1:0] {
        EMIT_EMPTY,
        EMIT_REQ,
        EMIT_WAIT
    } emitStateT;

endpackage

`default_nettype wire
